//--- cam_capture.f
hw/cam_capture_pkg.sv
hw/cam_pixel_assembler.sv
hw/box_filter_2x2.sv
hw/frame_write_addr.sv
hw/cam_capture_top.sv
dv/cam_capture_tb.sv

//--- dv/cam_capture_tb.sv
// testbench for the camera capture front end with xorshift sensor stimulus and a frame model
`timescale 1ns/1ps

module cam_capture_tb;

    localparam int src_pixels       = int'(cam_capture_pkg::src_h);
    localparam int dst_cols         = int'(cam_capture_pkg::dst_h);
    localparam int dst_rows         = int'(cam_capture_pkg::dst_v);
    localparam int skip_cols        = int'(cam_capture_pkg::out_skip);
    localparam int max_extra_pix    = 8;    // longest overrun of a long line
    localparam int min_blank        = 2;
    localparam int max_blank        = 20;
    localparam int extra_lines      = 3;    // odd count, next frame opens with line_odd set
    localparam int early_lines      = 4;    // href activity before the first vsync
    localparam int early_pixels     = 24;
    localparam int vsync_cycles     = 16;
    localparam int we_latency       = 3;
    localparam int drain_cycles     = 4 * we_latency;   // wait for the last writes of a frame
    localparam int max_line_cycles  = (src_pixels + max_extra_pix) * 2 + max_blank;
    localparam int frame_cycles     = (cam_capture_pkg::src_v + extra_lines + early_lines)
                                      * max_line_cycles + vsync_cycles;
    localparam int watchdog_cycles  = 2 * (2 * frame_cycles);
    localparam int writes_per_frame = dst_rows * (dst_cols - skip_cols);

    logic                               pclk;
    logic                               rst;
    logic                               vsync;
    logic                               href;
    logic [7:0]                         d;
    logic [cam_capture_pkg::addr_w-1:0] addr;
    logic [15:0]                        dout;
    logic                               we;

    logic [31:0]                        rng;            // xorshift state
    int                                 cycle;          // rising edges since time 0
    int                                 frame_writes;

    // reference model state
    logic [15:0]                        even_row [src_pixels];
    logic [cam_capture_pkg::addr_w-1:0] exp_addr_q [$];
    logic [15:0]                        exp_data_q [$];
    int                                 exp_cycle_q [$];   // cycle the last byte was driven

    cam_capture_top dut0 (
        .pclk  (pclk),
        .rst   (rst),
        .vsync (vsync),
        .href  (href),
        .d     (d),
        .addr  (addr),
        .dout  (dout),
        .we    (we)
    );

    always #5 pclk = ~pclk;

    always @(posedge pclk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name,
                              input logic [cam_capture_pkg::addr_w-1:0] got,
                              input logic [cam_capture_pkg::addr_w-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s expected 0x%05h got 0x%05h", $time, name, exp, got);
            abort_run("frame-buffer address does not match the model");
        end
    endtask

    task automatic check_pixel(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s expected 0x%04h got 0x%04h", $time, name, exp, got);
            abort_run("written pixel does not match the model");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, got);
            abort_run("count does not match the model");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // per-channel 4-pixel sum with the two low bits dropped
    function automatic logic [15:0] box_average(input logic [15:0] e0, input logic [15:0] e1,
                                                input logic [15:0] o0, input logic [15:0] o1);
        int         r;
        int         g;
        int         b;
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        r  = int'(e0[15:11]) + int'(e1[15:11]) + int'(o0[15:11]) + int'(o1[15:11]);
        g  = int'(e0[10:5]) + int'(e1[10:5]) + int'(o0[10:5]) + int'(o1[10:5]);
        b  = int'(e0[4:0]) + int'(e1[4:0]) + int'(o0[4:0]) + int'(o1[4:0]);
        r5 = 5'(r >> 2);
        g6 = 6'(g >> 2);
        b5 = 5'(b >> 2);
        if (cam_capture_pkg::bgr_order) begin
            return {b5, g6, r5};
        end
        return {r5, g6, b5};
    endfunction

    task automatic next_cycle();
        @(posedge pclk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            href = 1'b0;
            d    = 8'h00;
        end
    endtask

    // vsync pulse whose rising edge starts a frame
    task automatic start_frame();
        next_cycle();
        vsync = 1'b1;
        repeat (3) next_cycle();
        vsync = 1'b0;
        idle(8);
    endtask

    // sends one sensor line and models it when y is below src_v
    task automatic send_line(input int y, input int npix);
        logic [15:0] p;
        logic [15:0] odd_prev;
        int          c;
        int          blank;
        odd_prev = '0;
        for (int x = 0; x < npix; x++) begin
            rng = xorshift32(rng);
            p   = rng[15:0];
            next_cycle();
            href = 1'b1;
            d    = cam_capture_pkg::hi_byte_first ? p[15:8] : p[7:0];
            next_cycle();
            d    = cam_capture_pkg::hi_byte_first ? p[7:0] : p[15:8];
            if (y < cam_capture_pkg::src_v && x < src_pixels) begin
                if (y % 2 == 0) begin
                    even_row[x] = p;
                end else if (x % 2 == 0) begin
                    odd_prev = p;
                end else begin
                    c = x / 2;
                    if (c >= skip_cols) begin   // masked columns take no address
                        exp_addr_q.push_back(
                            cam_capture_pkg::addr_w'((y / 2) * dst_cols + c - skip_cols));
                        exp_data_q.push_back(box_average(even_row[x-1], even_row[x],
                                                         odd_prev, p));
                        exp_cycle_q.push_back(cycle);
                    end
                end
            end
        end
        rng   = xorshift32(rng);
        blank = min_blank + int'(rng % (max_blank - min_blank + 1));
        idle(blank);
    endtask

    task automatic run_frame(input int nlines);
        int npix;
        int waited;
        start_frame();
        for (int y = 0; y < nlines; y++) begin
            rng  = xorshift32(rng);
            npix = src_pixels;
            if (rng[2:0] == 3'd0) begin
                npix = src_pixels + 1 + int'(rng[5:3]);   // long line
            end
            send_line(y, npix);
        end
        waited = 0;
        while (exp_addr_q.size() != 0 && waited < drain_cycles) begin
            @(posedge pclk);
            waited++;
        end
        check_count("writes per frame", frame_writes, writes_per_frame);
        frame_writes = 0;
    endtask

    always @(negedge pclk) begin : write_monitor
        logic [cam_capture_pkg::addr_w-1:0] exp_addr;
        logic [15:0]                        exp_data;
        int                                 exp_cycle;
        if (!rst && we !== 1'b0) begin
            if (exp_addr_q.size() == 0) begin
                abort_run("write strobe seen with no pixel pending in the model");
            end else begin
                exp_addr  = exp_addr_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_addr("addr", addr, exp_addr);
                check_pixel("dout", dout, exp_data);
                check_count("we latency", cycle - exp_cycle, we_latency);
                frame_writes++;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge pclk);
        abort_run("watchdog expired before the run reached its end");
    end

    initial begin
        pclk         = 1'b0;
        rst          = 1'b1;
        vsync        = 1'b0;
        href         = 1'b0;
        d            = 8'h00;
        rng          = 32'hfc1c_0b60;
        cycle        = 0;
        frame_writes = 0;
        repeat (16) @(posedge pclk);
        #1;
        rst = 1'b0;

        // lines with no frame start yet must not write
        for (int i = 0; i < early_lines; i++) begin
            send_line(cam_capture_pkg::src_v, early_pixels);
        end
        idle(4);

        run_frame(cam_capture_pkg::src_v + extra_lines);
        run_frame(cam_capture_pkg::src_v);
        idle(16);

        if (exp_addr_q.size() == 0 && frame_writes == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("writes left over after the last frame");
        end
    end

endmodule

//--- hw/box_filter_2x2.sv
// 2x2 box filter that averages pixel pairs of an even and an odd line into one rgb565 pixel
`timescale 1ns/1ps

module box_filter_2x2 (
    input  logic        pclk,
    input  logic        rst,
    input  logic        pix_valid,
    input  logic [15:0] pix,
    input  logic        line_odd,
    input  logic        line_end,
    input  logic        frame_start,
    output logic        avg_valid,
    output logic [15:0] avg_pix,
    output logic        row_end,
    output logic        frame_start_o
);

    // pair sums of the even line, one per output column
    logic [cam_capture_pkg::pair_sum_w-1:0] line_buf [cam_capture_pkg::dst_h];

    logic [cam_capture_pkg::dst_x_w-1:0]    col;
    logic                                   have_p0;     // first pixel of a pair is held
    logic                                   pair_done;
    logic [15:0]                            p0;

    // fields of the held and the incoming pixel
    logic [4:0]                             r0;
    logic [5:0]                             g0;
    logic [4:0]                             b0;
    logic [4:0]                             r1;
    logic [5:0]                             g1;
    logic [4:0]                             b1;

    // horizontal pair sums
    logic [5:0]                             r_sum2;
    logic [6:0]                             g_sum2;
    logic [5:0]                             b_sum2;
    logic [cam_capture_pkg::pair_sum_w-1:0] pair_sum;

    // pair sums read back from the even line
    logic [5:0]                             r_prev2;
    logic [6:0]                             g_prev2;
    logic [5:0]                             b_prev2;

    // 4-pixel sums and their averages
    logic [6:0]                             r_sum4;
    logic [7:0]                             g_sum4;
    logic [6:0]                             b_sum4;
    logic [4:0]                             r_avg;
    logic [5:0]                             g_avg;
    logic [4:0]                             b_avg;

    assign {r0, g0, b0} = p0;
    assign {r1, g1, b1} = pix;

    assign pair_done = pix_valid & have_p0;

    assign r_sum2   = {1'b0, r0} + {1'b0, r1};
    assign g_sum2   = {1'b0, g0} + {1'b0, g1};
    assign b_sum2   = {1'b0, b0} + {1'b0, b1};
    assign pair_sum = {r_sum2, g_sum2, b_sum2};

    assign {r_prev2, g_prev2, b_prev2} = line_buf[col];

    assign r_sum4 = {1'b0, r_prev2} + {1'b0, r_sum2};
    assign g_sum4 = {1'b0, g_prev2} + {1'b0, g_sum2};
    assign b_sum4 = {1'b0, b_prev2} + {1'b0, b_sum2};

    // divide by four
    assign r_avg = r_sum4[6:2];
    assign g_avg = g_sum4[7:2];
    assign b_avg = b_sum4[6:2];

    always_ff @(posedge pclk) begin
        if (rst) begin
            have_p0       <= 1'b0;
            col           <= '0;
            avg_valid     <= 1'b0;
            row_end       <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            avg_valid     <= pair_done & line_odd;
            row_end       <= line_end & line_odd;
            frame_start_o <= frame_start;

            // cleared at each line end so the next line opens at column 0
            if (frame_start || line_end) begin
                have_p0 <= 1'b0;
                col     <= '0;
            end else if (pix_valid) begin
                have_p0 <= ~have_p0;
                if (have_p0 && col != cam_capture_pkg::dst_h - 1'b1) begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (pix_valid && !have_p0) begin
            p0 <= pix;
        end

        if (pair_done && !line_odd) begin
            line_buf[col] <= pair_sum;
        end

        if (pair_done && line_odd) begin
            if (cam_capture_pkg::bgr_order) begin
                avg_pix <= {b_avg, g_avg, r_avg};
            end else begin
                avg_pix <= {r_avg, g_avg, b_avg};
            end
        end
    end

endmodule

//--- hw/cam_capture_pkg.sv
// capture front end constants for frame geometry, byte and colour order, line skip and widths
package cam_capture_pkg;

    // counter and bus widths
    localparam int src_x_w    = 10;   // source pixel column, counts up to src_h
    localparam int dst_x_w    = 9;    // output column
    localparam int dst_y_w    = 8;    // output row, counts up to dst_v
    localparam int addr_w     = 17;   // frame-buffer word address

    // stored horizontal pair sum, packed as {r 6, g 7, b 6}
    localparam int pair_sum_w = 19;

    // source frame from the sensor, rgb565 at vga size
    localparam logic [src_x_w-1:0] src_h = src_x_w'(640);
    localparam int                 src_v = 480;

    // decimated frame written to the buffer
    localparam logic [dst_x_w-1:0] dst_h = dst_x_w'(320);
    localparam logic [dst_y_w-1:0] dst_v = dst_y_w'(240);

    // 1 means d carries bits 15..8 on the first byte of a pixel
    localparam bit hi_byte_first = 1'b1;

    // 1 swaps the red and blue fields of the written pixel
    localparam bit bgr_order = 1'b0;

    // source pixels at each line start whose outputs are masked
    localparam int line_skip_pixels = 4;

    // masked outputs per line, two source pixels per output, rounded up
    localparam logic [dst_x_w-1:0] out_skip = dst_x_w'((line_skip_pixels + 1) / 2);

endpackage

//--- hw/cam_capture_top.sv
// camera capture front end that turns ov7670 rgb565 bytes into half-size frame-buffer writes
`timescale 1ns/1ps

module cam_capture_top (
    input  logic                               pclk,
    input  logic                               rst,
    input  logic                               vsync,
    input  logic                               href,
    input  logic [7:0]                         d,
    output logic [cam_capture_pkg::addr_w-1:0] addr,
    output logic [15:0]                        dout,
    output logic                               we
);

    // assembler to filter
    logic        pix_valid;
    logic [15:0] pix;
    logic        line_odd;
    logic        line_end;
    logic        frame_start;

    // filter to write port
    logic        avg_valid;
    logic [15:0] avg_pix;
    logic        row_end;
    logic        frame_start_f;

    cam_pixel_assembler u_assembler (
        .pclk        (pclk),
        .rst         (rst),
        .vsync       (vsync),
        .href        (href),
        .d           (d),
        .pix_valid   (pix_valid),
        .pix         (pix),
        .line_odd    (line_odd),
        .line_end    (line_end),
        .frame_start (frame_start)
    );

    box_filter_2x2 u_filter (
        .pclk          (pclk),
        .rst           (rst),
        .pix_valid     (pix_valid),
        .pix           (pix),
        .line_odd      (line_odd),
        .line_end      (line_end),
        .frame_start   (frame_start),
        .avg_valid     (avg_valid),
        .avg_pix       (avg_pix),
        .row_end       (row_end),
        .frame_start_o (frame_start_f)
    );

    frame_write_addr u_write (
        .pclk        (pclk),
        .rst         (rst),
        .avg_valid   (avg_valid),
        .avg_pix     (avg_pix),
        .row_end     (row_end),
        .frame_start (frame_start_f),
        .addr        (addr),
        .dout        (dout),
        .we          (we)
    );

endmodule

//--- hw/cam_pixel_assembler.sv
// sensor byte assembler that finds sync edges, builds rgb565 pixels and tracks line parity
`timescale 1ns/1ps

module cam_pixel_assembler (
    input  logic        pclk,
    input  logic        rst,
    input  logic        vsync,
    input  logic        href,
    input  logic [7:0]  d,
    output logic        pix_valid,
    output logic [15:0] pix,
    output logic        line_odd,
    output logic        line_end,
    output logic        frame_start
);

    logic                                vsync_d;
    logic                                href_d;
    logic                                vsync_rise;
    logic                                href_rise;
    logic                                href_fall;
    logic                                byte_phase;   // 1 while waiting for the second byte
    logic                                second_byte;
    logic [7:0]                          first_byte;
    logic [cam_capture_pkg::src_x_w-1:0] src_x;        // saturates at src_h

    assign vsync_rise = vsync & ~vsync_d;
    assign href_rise  = href & ~href_d;
    assign href_fall  = ~href & href_d;

    // the byte on an href rise always opens a new pixel
    assign second_byte = href & byte_phase & ~href_rise;

    always_ff @(posedge pclk) begin
        if (rst) begin
            vsync_d     <= 1'b1;   // no false frame start if vsync is high out of reset
            href_d      <= 1'b0;
            byte_phase  <= 1'b0;
            src_x       <= '0;
            pix_valid   <= 1'b0;
            line_end    <= 1'b0;
            frame_start <= 1'b0;
            line_odd    <= 1'b0;
        end else begin
            vsync_d     <= vsync;
            href_d      <= href;
            line_end    <= href_fall;
            frame_start <= vsync_rise;

            // byte phase, restarted at every line start
            if (!href) begin
                byte_phase <= 1'b0;
            end else if (second_byte) begin
                byte_phase <= 1'b0;
            end else begin
                byte_phase <= 1'b1;
            end

            // pixels past the end of a long line are dropped
            pix_valid <= second_byte && (src_x < cam_capture_pkg::src_h);

            if (href_rise) begin
                src_x <= '0;
            end else if (second_byte && src_x != cam_capture_pkg::src_h) begin
                src_x <= src_x + 1'b1;
            end

            // toggles with the line_end strobe, so line_odd still names the ending line
            if (frame_start) begin
                line_odd <= 1'b0;
            end else if (line_end) begin
                line_odd <= ~line_odd;
            end
        end
    end

    // byte capture and pixel word
    always_ff @(posedge pclk) begin
        if (href && !second_byte) begin
            first_byte <= d;
        end
        if (second_byte) begin
            if (cam_capture_pkg::hi_byte_first) begin
                pix <= {first_byte, d};
            end else begin
                pix <= {d, first_byte};
            end
        end
    end

endmodule

//--- hw/frame_write_addr.sv
// frame-buffer write port that masks line-start outputs and keeps rows on dst_h boundaries
`timescale 1ns/1ps

module frame_write_addr (
    input  logic                               pclk,
    input  logic                               rst,
    input  logic                               avg_valid,
    input  logic [15:0]                        avg_pix,
    input  logic                               row_end,
    input  logic                               frame_start,
    output logic [cam_capture_pkg::addr_w-1:0] addr,
    output logic [15:0]                        dout,
    output logic                               we
);

    logic [cam_capture_pkg::addr_w-1:0]  wr_addr;    // next address to write
    logic [cam_capture_pkg::dst_x_w-1:0] wr_cnt;     // writes in the current row
    logic [cam_capture_pkg::dst_x_w-1:0] skip_cnt;   // outputs still to mask
    logic [cam_capture_pkg::dst_y_w-1:0] row_cnt;
    logic [cam_capture_pkg::dst_x_w-1:0] row_gap;
    logic [cam_capture_pkg::addr_w-1:0]  gap_ext;
    logic                                row_active;
    logic                                accept;
    logic                                take;

    assign row_active = row_cnt < cam_capture_pkg::dst_v;
    assign accept     = avg_valid & row_active & ~frame_start & ~row_end;
    assign take       = accept & (skip_cnt == '0);

    // addresses left unspent by the masked outputs
    assign row_gap = cam_capture_pkg::dst_h - wr_cnt;
    assign gap_ext = {{(cam_capture_pkg::addr_w - cam_capture_pkg::dst_x_w){1'b0}}, row_gap};

    always_ff @(posedge pclk) begin
        if (rst) begin
            we       <= 1'b0;
            wr_addr  <= '0;
            wr_cnt   <= '0;
            skip_cnt <= cam_capture_pkg::out_skip;
            row_cnt  <= cam_capture_pkg::dst_v;   // idle until the first frame start
        end else begin
            we <= take;

            if (frame_start) begin
                wr_addr  <= '0;
                wr_cnt   <= '0;
                skip_cnt <= cam_capture_pkg::out_skip;
                row_cnt  <= '0;
            end else if (row_end) begin
                // jump to the start of the next row
                if (row_active) begin
                    wr_addr <= wr_addr + gap_ext;
                    row_cnt <= row_cnt + 1'b1;
                end
                wr_cnt   <= '0;
                skip_cnt <= cam_capture_pkg::out_skip;
            end else if (accept) begin
                if (take) begin
                    wr_addr <= wr_addr + 1'b1;
                    wr_cnt  <= wr_cnt + 1'b1;
                end else begin
                    skip_cnt <= skip_cnt - 1'b1;   // masked, no address spent
                end
            end
        end
    end

    // held with we
    always_ff @(posedge pclk) begin
        if (take) begin
            addr <= wr_addr;
            dout <= avg_pix;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the camera capture testbench with verilator
set -e

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module cam_capture_tb \
    -f cam_capture.f \
    -o cam_capture_sim

# the log decides pass or fail, so a nonzero exit here is not fatal yet
./obj_dir/cam_capture_sim > "$log" 2>&1 || true
cat "$log"

if grep -q "TB FAILED" "$log"; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "TB PASSED" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
